/* verilog/monitor_pkg.sv */
// Widths, voltage thresholds, button patterns and the button, pad event and LED structs
`default_nettype none

package monitor_pkg;

    localparam int VOLT_WIDTH  = 14;
    localparam int LEVEL_WIDTH = 4;
    localparam int HISTORY_LEN = 16;
    localparam int SYNC_STAGES = 2;
    localparam int AVG_SHIFT   = 8;                        // 256 samples per average
    localparam int SUM_WIDTH   = VOLT_WIDTH + AVG_SHIFT;
    localparam int PWM_WIDTH   = 8;
    localparam int DUTY_SHIFT  = 4;

    // Buttons with a history window
    localparam int NUM_WATCHED = 3;
    localparam int WATCH_LEFT  = 0;
    localparam int WATCH_RIGHT = 1;
    localparam int WATCH_MENU  = 2;

    typedef logic [VOLT_WIDTH-1:0]  volt_t;
    typedef logic [LEVEL_WIDTH-1:0] level_t;

    localparam level_t LEVEL_MAX = 4'd15;

    // One released sample, then fifteen pressed ones
    localparam logic [HISTORY_LEN-1:0] PRESS_PATTERN   = {1'b1, {(HISTORY_LEN-1){1'b0}}};
    localparam logic [HISTORY_LEN-1:0] RELEASE_PATTERN = ~PRESS_PATTERN;

    localparam volt_t VOLT_VALID_MIN = 14'd700;            // About 1.8 V
    localparam volt_t LOWPOWER_ENTER = 14'd979;            // 2.55 V
    localparam volt_t LOWPOWER_EXIT  = 14'd1293;           // 3.4 V
    localparam volt_t FULL_LI        = 14'd1423;           // 3.75 V
    localparam volt_t FULL_AA        = 14'd1367;           // 3.6 V
    localparam volt_t RED_LI         = 14'd1182;           // 3.1 V
    localparam volt_t RED_AA         = 14'd1071;           // 2.8 V

    // Levels are active low, 0 = pressed
    typedef struct packed {
        logic a;
        logic b;
        logic select;
        logic start;
        logic up;
        logic down;
        logic left;
        logic right;
        logic menu;
    } buttons_t;

    typedef struct packed {
        logic left_press;                                  // One-cycle pulse
        logic right_press;                                 // One-cycle pulse
        logic menu_held;                                   // Level
    } pad_events_t;

    typedef struct packed {
        logic red;
        logic white;
    } leds_t;

endpackage

`default_nettype wire

/* verilog/button_input.sv */
// Button synchronisers, history windows, pad step events and the menu toggle
`timescale 1ns/1ps
`default_nettype none

module button_input (
    input  wire                          clk,
    input  wire                          reset,
    input  wire monitor_pkg::buttons_t   btn,
    output monitor_pkg::pad_events_t     events,
    output logic                         menu_open
);

    import monitor_pkg::*;

    buttons_t [SYNC_STAGES-1:0]             sync_q;
    buttons_t                               btn_s;
    logic [NUM_WATCHED-1:0]                 watched;
    logic [NUM_WATCHED-1:0][HISTORY_LEN-1:0] hist_q;
    logic [NUM_WATCHED-1:0]                 pressed;
    logic                                   menu_released;
    logic                                   others_down;
    logic                                   menu_armed_q;

    assign btn_s = sync_q[SYNC_STAGES-1];

    assign watched[WATCH_LEFT]  = btn_s.left;
    assign watched[WATCH_RIGHT] = btn_s.right;
    assign watched[WATCH_MENU]  = btn_s.menu;

    // Released is 1, so reset fills everything with ones
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_q <= '1;
            hist_q <= '1;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], btn};
            for (int i = 0; i < NUM_WATCHED; i++) begin
                hist_q[i] <= {hist_q[i][HISTORY_LEN-2:0], watched[i]}; // Oldest at top
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_WATCHED; i++) begin
            pressed[i] = (hist_q[i] == PRESS_PATTERN);
        end
    end

    assign menu_released = (hist_q[WATCH_MENU] == RELEASE_PATTERN);

    // Any button other than menu held down
    assign others_down = ~&{btn_s.a, btn_s.b, btn_s.select, btn_s.start,
                            btn_s.up, btn_s.down, btn_s.left, btn_s.right};

    assign events.left_press  = pressed[WATCH_LEFT];
    assign events.right_press = pressed[WATCH_RIGHT];
    assign events.menu_held   = ~btn_s.menu;

    // Press arms, settled release toggles, other buttons cancel
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            menu_armed_q <= 1'b0;
            menu_open    <= 1'b0;
        end else begin
            if (pressed[WATCH_MENU]) begin
                menu_armed_q <= 1'b1;
            end
            if (menu_released && menu_armed_q) begin
                menu_open    <= ~menu_open;
                menu_armed_q <= 1'b0;
            end
            if (others_down) begin
                menu_armed_q <= 1'b0;                      // Combo, not a menu tap
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/backlight_control.sv */
// Backlight level register with pad stepping and AA low-power save and restore
`timescale 1ns/1ps
`default_nettype none

module backlight_control (
    input  wire                            clk,
    input  wire                            reset,
    input  wire monitor_pkg::pad_events_t  events,
    input  wire                            menu_open,
    input  wire monitor_pkg::volt_t        volt,
    input  wire                            bat_lithium,
    output monitor_pkg::level_t            level
);

    import monitor_pkg::*;

    logic   lowpower_q;
    level_t saved_q;
    logic   steps_enabled;
    logic   aa_valid;
    logic   enter_lowpower;
    logic   exit_lowpower;

    assign steps_enabled = ~menu_open & ~events.menu_held;

    // Thresholds only mean something for AA cells with a sane reading
    assign aa_valid       = ~bat_lithium && (volt >= VOLT_VALID_MIN);
    assign enter_lowpower = aa_valid && ~lowpower_q && (volt < LOWPOWER_ENTER);
    assign exit_lowpower  = aa_valid && lowpower_q && (volt > LOWPOWER_EXIT);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            level      <= '0;
            lowpower_q <= 1'b0;
        end else begin
            if (steps_enabled && events.left_press && (level != '0)) begin
                level <= level - 1'b1;
            end
            if (steps_enabled && events.right_press && (level != LEVEL_MAX)) begin
                level <= level + 1'b1;
            end

            if (lowpower_q) begin
                level <= '0;                               // Overrides any step
            end

            if (enter_lowpower) begin
                lowpower_q <= 1'b1;
            end else if (exit_lowpower) begin
                lowpower_q <= 1'b0;
                level      <= saved_q;                     // Back to the old level
            end
        end
    end

    // Level in force when low power was entered
    always_ff @(posedge clk) begin
        if (enter_lowpower) begin
            saved_q <= level;
        end
    end

endmodule

`default_nettype wire

/* verilog/battery_average.sv */
// Battery voltage averaging over groups of 256 ADC samples
`timescale 1ns/1ps
`default_nettype none

module battery_average (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      adc_valid,
    input  wire monitor_pkg::volt_t  adc_value,
    output monitor_pkg::volt_t       volt,
    output logic                     volt_update
);

    import monitor_pkg::*;

    logic [SUM_WIDTH-1:0] sum_q;
    logic [SUM_WIDTH-1:0] sum_next;
    logic [AVG_SHIFT-1:0] count_q;
    logic                 group_done;

    assign sum_next   = sum_q + SUM_WIDTH'(adc_value);
    assign group_done = adc_valid && (count_q == '1);      // 256th sample

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sum_q       <= '0;
            count_q     <= '0;
            volt        <= '0;
            volt_update <= 1'b0;
        end else begin
            volt_update <= 1'b0;
            if (adc_valid) begin
                count_q <= count_q + 1'b1;                 // Wraps to 0 with the group
                sum_q   <= group_done ? '0 : sum_next;
            end
            if (group_done) begin
                volt        <= sum_next[SUM_WIDTH-1:AVG_SHIFT];
                volt_update <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/battery_indicator.sv */
// Low-battery flag, blinking red LED and white charge LED
`timescale 1ns/1ps
`default_nettype none

module battery_indicator (
    input  wire                      clk,
    input  wire                      reset,
    input  wire monitor_pkg::volt_t  volt,
    input  wire                      charging,
    input  wire                      bat_lithium,
    input  wire                      second_tick,
    output logic                     low_battery,
    output monitor_pkg::leds_t       leds
);

    import monitor_pkg::*;

    volt_t full_level;
    volt_t red_level;
    logic  blink_q;
    logic  volt_valid;
    logic  below_red;
    logic  below_full;

    assign full_level = bat_lithium ? FULL_LI : FULL_AA;
    assign red_level  = bat_lithium ? RED_LI : RED_AA;

    assign volt_valid = (volt >= VOLT_VALID_MIN);
    assign below_red  = volt_valid && ~charging && (volt < red_level);
    assign below_full = volt_valid && charging && bat_lithium && (volt < full_level);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            blink_q     <= 1'b0;
            low_battery <= 1'b0;
            leds        <= '0;
        end else begin
            if (second_tick) begin
                blink_q <= ~blink_q;
            end
            low_battery <= below_red;
            leds.red    <= below_red && blink_q;           // 1 s on, 1 s off
            leds.white  <= below_full;                     // Lithium still charging
        end
    end

endmodule

`default_nettype wire

/* verilog/backlight_pwm.sv */
// Backlight PWM, free-running counter compared against the scaled level
`timescale 1ns/1ps
`default_nettype none

module backlight_pwm (
    input  wire                       clk,
    input  wire                       reset,
    input  wire monitor_pkg::level_t  level,
    output logic                      lcd_pwm
);

    import monitor_pkg::*;

    logic [PWM_WIDTH-1:0] count_q;
    logic [PWM_WIDTH-1:0] duty;

    assign duty = {level, {DUTY_SHIFT{1'b0}}};             // Level times 16

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

    // High for duty + 1 counts per period
    assign lcd_pwm = (count_q <= duty);

endmodule

`default_nettype wire

/* verilog/system_monitor.sv */
// Housekeeping top level joining buttons, backlight and battery monitoring
`timescale 1ns/1ps
`default_nettype none

module system_monitor (
    input  wire                          clk,
    input  wire                          reset,
    input  wire monitor_pkg::buttons_t   btn,
    input  wire                          adc_valid,
    input  wire monitor_pkg::volt_t      adc_value,
    input  wire                          second_tick,
    input  wire                          charging,
    input  wire                          bat_lithium,
    output logic                         menu_open,
    output monitor_pkg::level_t          level,
    output logic                         lcd_pwm,
    output logic                         low_battery,
    output monitor_pkg::leds_t           leds,
    output monitor_pkg::volt_t           volt
);

    import monitor_pkg::*;

    pad_events_t events;

    button_input buttons_i (
        .clk       (clk),
        .reset     (reset),
        .btn       (btn),
        .events    (events),
        .menu_open (menu_open)
    );

    backlight_control control_i (
        .clk         (clk),
        .reset       (reset),
        .events      (events),
        .menu_open   (menu_open),
        .volt        (volt),
        .bat_lithium (bat_lithium),
        .level       (level)
    );

    battery_average average_i (
        .clk         (clk),
        .reset       (reset),
        .adc_valid   (adc_valid),
        .adc_value   (adc_value),
        .volt        (volt),
        .volt_update ()                                    // No consumer here
    );

    battery_indicator indicator_i (
        .clk         (clk),
        .reset       (reset),
        .volt        (volt),
        .charging    (charging),
        .bat_lithium (bat_lithium),
        .second_tick (second_tick),
        .low_battery (low_battery),
        .leds        (leds)
    );

    backlight_pwm pwm_i (
        .clk     (clk),
        .reset   (reset),
        .level   (level),
        .lcd_pwm (lcd_pwm)
    );

endmodule

`default_nettype wire

/* verification/system_monitor_tb.sv */
// Testbench for the housekeeping monitor, a table of actions and expected values run in a loop
`timescale 1ns/1ps
`default_nettype none

module system_monitor_tb;

    import monitor_pkg::*;

    localparam int HOLD_CYCLES = 40;                       // Beyond sync plus history window
    localparam int WAIT_LIMIT  = 100;
    localparam int RAND_BITS   = 6;

    // Bit positions inside buttons_t
    localparam int BTN_MENU  = 0;
    localparam int BTN_RIGHT = 1;
    localparam int BTN_LEFT  = 2;
    localparam int BTN_A     = 8;

    localparam logic [3:0] ACT_PRESS     = 4'd0;
    localparam logic [3:0] ACT_RELEASE   = 4'd1;
    localparam logic [3:0] ACT_TAP       = 4'd2;       // Press and release, op_b times
    localparam logic [3:0] ACT_SAMPLES   = 4'd3;
    localparam logic [3:0] ACT_TICKS     = 4'd4;
    localparam logic [3:0] ACT_SET       = 4'd5;       // op_a = {charging, bat_lithium}
    localparam logic [3:0] ACT_EXP_LEVEL = 4'd6;
    localparam logic [3:0] ACT_EXP_MENU  = 4'd7;
    localparam logic [3:0] ACT_EXP_LEDS  = 4'd8;       // {low_battery, red, white}
    localparam logic [3:0] ACT_EXP_VOLT  = 4'd9;
    localparam logic [3:0] ACT_PWM       = 4'd10;

    typedef struct packed {
        logic [3:0]  action;
        logic [15:0] op_a;
        logic [15:0] op_b;
        logic [15:0] expected;
    } row_t;

    logic     clk;
    logic     reset;
    buttons_t btn;
    logic     adc_valid;
    volt_t    adc_value;
    logic     second_tick;
    logic     charging;
    logic     bat_lithium;
    logic     menu_open;
    level_t   level;
    logic     lcd_pwm;
    logic     low_battery;
    leds_t    leds;
    volt_t    volt;

    row_t        rows[$];
    logic [31:0] lfsr_state;
    int          expected_volt;
    int          error_count;
    int          timeout_count;

    system_monitor dut_i (
        .clk         (clk),
        .reset       (reset),
        .btn         (btn),
        .adc_valid   (adc_valid),
        .adc_value   (adc_value),
        .second_tick (second_tick),
        .charging    (charging),
        .bat_lithium (bat_lithium),
        .menu_open   (menu_open),
        .level       (level),
        .lcd_pwm     (lcd_pwm),
        .low_battery (low_battery),
        .leds        (leds),
        .volt        (volt)
    );

    always begin
        #4;
        clk = 1'b1;
        #4;
        clk = 1'b0;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic take_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            error_count++;
            $display("error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    function automatic string signal_name(input logic [3:0] action);
        case (action)
            ACT_EXP_LEVEL: return "level";
            ACT_EXP_MENU:  return "menu_open";
            ACT_EXP_LEDS:  return "low_battery/leds";
            default:       return "volt";
        endcase
    endfunction

    function automatic int observed(input logic [3:0] action);
        case (action)
            ACT_EXP_LEVEL: return int'(level);
            ACT_EXP_MENU:  return int'(menu_open);
            ACT_EXP_LEDS:  return int'({low_battery, leds.red, leds.white});
            default:       return int'(volt);
        endcase
    endfunction

    // Polls the output until it matches, then compares once more
    task automatic expect_output(input logic [3:0] action, input int expected);
        int cycles;
        cycles = 0;
        while ((observed(action) != expected) && (cycles < WAIT_LIMIT)) begin
            @(negedge clk);
            cycles++;
        end
        if (observed(action) != expected) begin
            timeout_count++;
            $display("timeout: %s did not reach %0d within %0d cycles",
                     signal_name(action), expected, WAIT_LIMIT);
        end
        check_value(signal_name(action), expected, observed(action));
    endtask

    task automatic set_button(input int index, input logic value);
        buttons_t next_btn;
        next_btn = btn;
        next_btn[index] = value;                           // 0 = pressed
        btn <= next_btn;
        repeat (HOLD_CYCLES) @(negedge clk);
    endtask

    task automatic send_samples(input int count, input int base);
        int sum;
        int bits;
        sum = 0;
        for (int i = 0; i < count; i++) begin
            take_bits(RAND_BITS, bits);
            adc_value <= volt_t'(base + bits);
            adc_valid <= 1'b1;
            sum += base + bits;
            @(negedge clk);
        end
        adc_valid <= 1'b0;
        expected_volt = sum / 256;                         // Floor of the mean
    endtask

    task automatic pulse_ticks(input int count);
        repeat (count) begin
            second_tick <= 1'b1;
            @(negedge clk);
            second_tick <= 1'b0;
            repeat (3) @(negedge clk);
        end
    endtask

    task automatic measure_pwm(input int expected);
        int high_cycles;
        high_cycles = 0;
        repeat (1 << PWM_WIDTH) begin
            @(negedge clk);
            if (lcd_pwm) begin
                high_cycles++;
            end
        end
        check_value("lcd_pwm high cycles", expected, high_cycles);
    endtask

    task automatic apply_row(input row_t row);
        case (row.action)
            ACT_PRESS:   set_button(row.op_a, 1'b0);
            ACT_RELEASE: set_button(row.op_a, 1'b1);
            ACT_TAP: begin
                repeat (row.op_b) begin
                    set_button(row.op_a, 1'b0);
                    set_button(row.op_a, 1'b1);
                end
            end
            ACT_SAMPLES: send_samples(row.op_a, row.op_b);
            ACT_TICKS:   pulse_ticks(row.op_a);
            ACT_SET: begin
                charging    <= row.op_a[1];
                bat_lithium <= row.op_a[0];
                @(negedge clk);
            end
            ACT_EXP_LEVEL, ACT_EXP_MENU, ACT_EXP_LEDS: expect_output(row.action, row.expected);
            ACT_EXP_VOLT: expect_output(row.action, expected_volt);
            ACT_PWM:      measure_pwm(row.expected);
            default: begin
                error_count++;
                $display("the table holds an unknown action %0d", row.action);
            end
        endcase
    endtask

    task automatic add_row(input logic [3:0] action, input int a, input int b, input int exp);
        row_t row;
        row.action   = action;
        row.op_a     = 16'(a);
        row.op_b     = 16'(b);
        row.expected = 16'(exp);
        rows.push_back(row);
    endtask

    task automatic load_table();
        add_row(ACT_EXP_MENU, 0, 0, 0);                    // State after reset
        add_row(ACT_EXP_LEVEL, 0, 0, 0);
        add_row(ACT_EXP_LEDS, 0, 0, 0);
        add_row(ACT_EXP_VOLT, 0, 0, 0);
        add_row(ACT_SET, 2'b01, 0, 0);
        add_row(ACT_TAP, BTN_RIGHT, 3, 0);
        add_row(ACT_EXP_LEVEL, 0, 0, 3);
        add_row(ACT_PWM, 0, 0, 3 * 16 + 1);
        add_row(ACT_TAP, BTN_RIGHT, 14, 0);                // Saturates at the top
        add_row(ACT_EXP_LEVEL, 0, 0, 15);
        add_row(ACT_PWM, 0, 0, 15 * 16 + 1);
        add_row(ACT_TAP, BTN_LEFT, 3, 0);
        add_row(ACT_EXP_LEVEL, 0, 0, 12);
        add_row(ACT_TAP, BTN_LEFT, 14, 0);
        add_row(ACT_EXP_LEVEL, 0, 0, 0);
        add_row(ACT_PWM, 0, 0, 1);
        add_row(ACT_TAP, BTN_RIGHT, 5, 0);
        add_row(ACT_EXP_LEVEL, 0, 0, 5);
        add_row(ACT_PWM, 0, 0, 5 * 16 + 1);
        add_row(ACT_TAP, BTN_MENU, 1, 0);
        add_row(ACT_EXP_MENU, 0, 0, 1);
        add_row(ACT_TAP, BTN_RIGHT, 2, 0);                 // Ignored while the menu is open
        add_row(ACT_TAP, BTN_LEFT, 1, 0);
        add_row(ACT_EXP_LEVEL, 0, 0, 5);
        add_row(ACT_TAP, BTN_MENU, 1, 0);
        add_row(ACT_EXP_MENU, 0, 0, 0);
        add_row(ACT_PRESS, BTN_MENU, 0, 0);                // Menu plus A is a combo
        add_row(ACT_PRESS, BTN_A, 0, 0);
        add_row(ACT_RELEASE, BTN_A, 0, 0);
        add_row(ACT_RELEASE, BTN_MENU, 0, 0);
        add_row(ACT_EXP_MENU, 0, 0, 0);
        add_row(ACT_SAMPLES, 256, 2000, 0);
        add_row(ACT_EXP_VOLT, 0, 0, 0);
        add_row(ACT_SET, 2'b00, 0, 0);                     // AA, not charging
        add_row(ACT_SAMPLES, 256, 1000, 0);
        add_row(ACT_EXP_VOLT, 0, 0, 0);
        add_row(ACT_EXP_LEDS, 0, 0, 3'b100);
        add_row(ACT_TICKS, 1, 0, 0);
        add_row(ACT_EXP_LEDS, 0, 0, 3'b110);
        add_row(ACT_TICKS, 1, 0, 0);
        add_row(ACT_EXP_LEDS, 0, 0, 3'b100);
        add_row(ACT_EXP_LEVEL, 0, 0, 5);
        add_row(ACT_SET, 2'b11, 0, 0);                     // Lithium, charging
        add_row(ACT_SAMPLES, 256, 1300, 0);
        add_row(ACT_EXP_LEDS, 0, 0, 3'b001);
        add_row(ACT_SET, 2'b01, 0, 0);
        add_row(ACT_TAP, BTN_RIGHT, 4, 0);
        add_row(ACT_EXP_LEVEL, 0, 0, 9);
        add_row(ACT_SET, 2'b00, 0, 0);
        add_row(ACT_SAMPLES, 256, 900, 0);                 // Below the low-power entry
        add_row(ACT_EXP_VOLT, 0, 0, 0);
        add_row(ACT_EXP_LEVEL, 0, 0, 0);
        add_row(ACT_TAP, BTN_RIGHT, 2, 0);
        add_row(ACT_EXP_LEVEL, 0, 0, 0);
        add_row(ACT_SAMPLES, 256, 1300, 0);
        add_row(ACT_EXP_LEVEL, 0, 0, 9);
        add_row(ACT_SET, 2'b01, 0, 0);
        add_row(ACT_SAMPLES, 256, 900, 0);
        add_row(ACT_EXP_VOLT, 0, 0, 0);
        add_row(ACT_EXP_LEVEL, 0, 0, 9);
        add_row(ACT_PWM, 0, 0, 9 * 16 + 1);                // Level holds with a lithium cell
        add_row(ACT_SAMPLES, 256, 1300, 0);
        add_row(ACT_EXP_LEVEL, 0, 0, 9);
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        btn           = '1;
        adc_valid     = 1'b0;
        adc_value     = '0;
        second_tick   = 1'b0;
        charging      = 1'b0;
        bat_lithium   = 1'b1;
        lfsr_state    = 32'hfbf2_ef8a;
        expected_volt = 0;
        error_count   = 0;
        timeout_count = 0;
        load_table();
        repeat (8) @(negedge clk);
        reset <= 1'b0;
        @(negedge clk);
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        $display("check errors %0d, timeouts %0d", error_count, timeout_count);
        if ((error_count == 0) && (timeout_count == 0)) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* system_monitor.f */
verilog/monitor_pkg.sv
verilog/button_input.sv
verilog/backlight_control.sv
verilog/battery_average.sv
verilog/battery_indicator.sv
verilog/backlight_pwm.sv
verilog/system_monitor.sv
verification/system_monitor_tb.sv
